/* filelist.f */
src/cnn_cmd_pkg.sv
src/cnn_data_pkg.sv
src/csb.sv
src/conv3x3_mac.sv
src/pool3x3_max.sv
src/cnn_core_top.sv
tests/cnn_core_asserts.sv
tests/cnn_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CNN core testbench with Verilator
LOG=sim.log

rm -rf obj_dir "$LOG" && \
verilator --binary --timing --assert -Wno-fatal --top-module cnn_core_tb -f filelist.f \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vcnn_core_tb > "$LOG" 2>&1 || echo "Test failures found" >> "$LOG"
cat "$LOG"
grep -q "Test failures found" "$LOG" && { echo "Simulation FAILED"; exit 1; } || echo "Simulation passed"

/* tests/cnn_core_tb.sv */
module cnn_core_tb;
    import cnn_cmd_pkg::*;
    import cnn_data_pkg::*;

    localparam int FRAC_BITS = 8;
    localparam int N_ROWS = 8;
    localparam logic [31:0] SEED = 32'hfea705c3;

    // One command of the stimulus table
    typedef struct packed {
        logic        run;
        logic [2:0]  op;
        logic [15:0] windows;
        logic [31:0] base;
        logic [15:0] w_range;
        logic [15:0] p_range;
        logic        p_neg;
    } cmd_row_t;

    // Expected result and the table row it belongs to
    typedef struct packed {
        logic [31:0]        w_addr;
        logic signed [15:0] value;
        logic [7:0]         idx;
    } expect_t;

    // run, op code, windows, write base, weight range, pixel range, all negative
    cmd_row_t cmd_table [N_ROWS] = '{
        '{1'b0, 3'd1, 16'd6, 32'h0000_1000, 16'd16,   16'd128,    1'b0},
        '{1'b0, 3'd3, 16'd5, 32'h0000_2000, 16'd0,    16'd4096,   1'b0},
        '{1'b0, 3'd5, 16'd3, 32'h0000_3000, 16'd0,    16'd128,    1'b0},
        '{1'b0, 3'd1, 16'd6, 32'h0000_4000, 16'd8192, 16'd4096,   1'b0},
        '{1'b0, 3'd3, 16'd4, 32'h0000_5000, 16'd0,    16'd256,    1'b1},
        '{1'b1, 3'd3, 16'd3, 32'h0000_6000, 16'd0,    16'h8000,   1'b0},
        '{1'b1, 3'd1, 16'd4, 32'h0000_7000, 16'd256,  16'd256,    1'b0},
        '{1'b1, 3'd7, 16'd2, 32'h0000_8000, 16'd0,    16'd64,     1'b0}
    };

    logic clk;
    logic rst_n = 1'b0;
    logic op_en = 1'b0;
    logic [31:0] cmd = '0;
    logic cmd_fifo_empty = 1'b1;
    logic [31:0] data = '0;
    logic im_fifo_empty = 1'b1;
    logic [31:0] weightbias = '0;
    logic iwb_fifo_empty = 1'b1;
    logic result_ready = 1'b0;
    logic cmd_fifo_rd_en;
    logic im_fifo_rd_en;
    logic iwb_fifo_rd_en;
    logic result_valid;
    result_t result;
    logic irq;

    logic [31:0] cmd_q [$];
    logic [31:0] im_q [$];
    logic [31:0] wb_q [$];
    expect_t exp_q [$];
    logic [31:0] pix_seed = SEED;
    logic [31:0] ready_seed = SEED;
    logic held = 1'b0;
    result_t held_res;
    int checks = 0;
    int errors = 0;
    int tests_done = 0;
    int tests_failed = 0;
    int got [N_ROWS] = '{default: 0};
    int row_err [N_ROWS] = '{default: 0};
    bit reported [N_ROWS] = '{default: 1'b0};

    cnn_core_top #(
        .frac_bits (FRAC_BITS)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_en          (op_en),
        .cmd_fifo_rd_en (cmd_fifo_rd_en),
        .cmd            (cmd),
        .cmd_fifo_empty (cmd_fifo_empty),
        .im_fifo_rd_en  (im_fifo_rd_en),
        .data           (data),
        .im_fifo_empty  (im_fifo_empty),
        .iwb_fifo_rd_en (iwb_fifo_rd_en),
        .weightbias     (weightbias),
        .iwb_fifo_empty (iwb_fifo_empty),
        .result_valid   (result_valid),
        .result         (result),
        .result_ready   (result_ready),
        .irq            (irq)
    );

    bind csb cnn_core_asserts u_asserts (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic pick_value(input int range, input bit neg, output logic signed [15:0] v);
        int r;
        pix_seed = lcg_next(pix_seed);
        r = int'(pix_seed[31:16]);
        if (neg) v = 16'(-1 - (r % range));
        else v = 16'((r % (2 * range)) - range);
    endtask

    // Sum of products plus bias, scaled, ReLU, saturated
    function automatic logic signed [15:0] conv_ref(input window_t px, input weight_set_t ws);
        int acc;
        acc = int'($signed(ws.bias));
        for (int k = 0; k < WIN_PIX; k++) begin
            acc = acc + int'($signed(px[k])) * int'($signed(ws.w[k]));
        end
        acc = acc >>> FRAC_BITS;
        if (acc < 0) return 16'sd0;
        if (acc > 32767) return 16'sd32767;
        return 16'(acc);
    endfunction

    function automatic logic signed [15:0] pool_ref(input window_t px);
        logic signed [15:0] m;
        m = px[0];
        for (int k = 1; k < WIN_PIX; k++) begin
            if ($signed(px[k]) > m) m = px[k];
        end
        return m;
    endfunction

    function automatic int total_windows();
        int n;
        n = 0;
        for (int i = 0; i < N_ROWS; i++) n += int'(cmd_table[i].windows);
        return n;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic report_row(input int i);
        int want;
        want = (cmd_table[i].op == 3'd1 || cmd_table[i].op == 3'd3) ?
               int'(cmd_table[i].windows) : 0;
        reported[i] = 1'b1;
        tests_done++;
        if (row_err[i] == 0 && got[i] == want) begin
            $display("test %0d op %0d: %0d of %0d results ok", i, cmd_table[i].op, got[i], want);
        end else begin
            tests_failed++;
            $display("test %0d op %0d: %0d of %0d results, %0d wrong", i, cmd_table[i].op,
                     got[i], want, row_err[i]);
        end
    endtask

    // Five FIFO words, low half first
    task automatic push_halves(input bit to_image, input logic [15:0] h [10]);
        logic [31:0] w;
        for (int k = 0; k < OPERAND_WORDS; k++) begin
            w = {h[2*k+1], h[2*k]};
            if (to_image) im_q.push_back(w);
            else wb_q.push_back(w);
        end
    endtask

    task automatic load_run(input int run);
        window_t px;
        weight_set_t ws;
        logic [15:0] half [10];
        logic signed [15:0] v;
        expect_t ev;
        ws = '0;
        for (int i = 0; i < N_ROWS; i++) begin
            if (int'(cmd_table[i].run) != run) continue;
            cmd_q.push_back({29'd0, cmd_table[i].op});
            cmd_q.push_back({16'd0, cmd_table[i].windows});
            cmd_q.push_back(cmd_table[i].base ^ 32'h8000_0000);
            cmd_q.push_back(cmd_table[i].base);
            if (cmd_table[i].op != 3'd1 && cmd_table[i].op != 3'd3) continue;
            if (cmd_table[i].op == 3'd1) begin
                for (int k = 0; k < 10; k++) begin
                    pick_value(int'(cmd_table[i].w_range), 1'b0, v);
                    half[k] = v;
                    if (k < WIN_PIX) ws.w[k] = v;
                    else ws.bias = v;
                end
                push_halves(1'b0, half);
            end
            for (int n = 0; n < int'(cmd_table[i].windows); n++) begin
                for (int k = 0; k < WIN_PIX; k++) begin
                    pick_value(int'(cmd_table[i].p_range), cmd_table[i].p_neg, v);
                    px[k] = v;
                    half[k] = v;
                end
                // Padding in the unused high half
                pick_value(16384, 1'b0, v);
                half[9] = v;
                push_halves(1'b1, half);
                ev.w_addr = cmd_table[i].base + 32'(2 * n);
                ev.value = (cmd_table[i].op == 3'd1) ? conv_ref(px, ws) : pool_ref(px);
                ev.idx = 8'(i);
                exp_q.push_back(ev);
            end
        end
    endtask

    task automatic close_run(input int run);
        int e0;
        e0 = errors;
        check_value(32'(exp_q.size()), 32'd0, "results still missing when irq rose");
        check_value(32'(cmd_q.size()), 32'd0, "command words left over");
        check_value(32'(im_q.size()), 32'd0, "image words left over");
        check_value(32'(wb_q.size()), 32'd0, "weight words left over");
        for (int i = 0; i < N_ROWS; i++) begin
            if (int'(cmd_table[i].run) == run && !reported[i]) report_row(i);
        end
        // irq holds while op_en stays high
        repeat (5) begin
            @(posedge clk);
            check_value(32'(irq), 32'd1, "irq dropped while op_en high");
            check_value(32'(result_valid), 32'd0, "result_valid while finished");
        end
        op_en <= 1'b0;
        @(posedge clk);
        while (irq) @(posedge clk);
        tests_done++;
        if (errors != e0) begin
            tests_failed++;
            $display("run %0d completion and irq: failed", run);
        end else begin
            $display("run %0d completion and irq: ok", run);
        end
    endtask

    // FWFT FIFO models, head word shown while not empty
    always @(posedge clk) begin
        if (cmd_fifo_rd_en && cmd_q.size() > 0) void'(cmd_q.pop_front());
        if (im_fifo_rd_en && im_q.size() > 0) void'(im_q.pop_front());
        if (iwb_fifo_rd_en && wb_q.size() > 0) void'(wb_q.pop_front());
        cmd <= (cmd_q.size() > 0) ? cmd_q[0] : 32'd0;
        cmd_fifo_empty <= (cmd_q.size() == 0);
        data <= (im_q.size() > 0) ? im_q[0] : 32'd0;
        im_fifo_empty <= (im_q.size() == 0);
        weightbias <= (wb_q.size() > 0) ? wb_q[0] : 32'd0;
        iwb_fifo_empty <= (wb_q.size() == 0);
    end

    // Random back-pressure, ready about three cycles in four
    always @(posedge clk) begin
        ready_seed = lcg_next(ready_seed);
        result_ready <= ready_seed[30] | ready_seed[17];
    end

    // Result monitor
    always @(posedge clk) begin
        int e0;
        expect_t ev;
        if (rst_n && held) begin
            check_value(32'(result_valid), 32'd1, "result_valid dropped while stalled");
            check_value(result.w_addr, held_res.w_addr, "w_addr changed while stalled");
            check_value(result.value, held_res.value, "value changed while stalled");
        end
        if (rst_n && result_valid && result_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected extra result at time %0t, address %h", $time,
                         result.w_addr);
            end else begin
                ev = exp_q.pop_front();
                e0 = errors;
                check_value(result.w_addr, ev.w_addr, $sformatf("test %0d address", ev.idx));
                check_value(result.value, ev.value,
                            $sformatf("test %0d value at %h", ev.idx, ev.w_addr));
                if (errors != e0) row_err[ev.idx]++;
                got[ev.idx]++;
                if (got[ev.idx] == int'(cmd_table[ev.idx].windows)) report_row(int'(ev.idx));
            end
        end
        held = rst_n && result_valid && !result_ready;
        held_res = result;
    end

    initial begin
        int limit;
        limit = total_windows() * 200 + 500;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        repeat (3) @(posedge clk);
        check_value(32'({cmd_fifo_rd_en, im_fifo_rd_en, iwb_fifo_rd_en, result_valid, irq}),
                    32'd0, "outputs not idle in reset");
        @(posedge clk);
        rst_n <= 1'b1;
        for (int run = 0; run < 2; run++) begin
            @(negedge clk);
            load_run(run);
            @(posedge clk);
            op_en <= 1'b1;
            while (irq !== 1'b1) @(posedge clk);
            close_run(run);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_done, tests_failed,
                 checks, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tests/cnn_core_asserts.sv */
module cnn_core_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 cmd_fifo_rd_en,
    input logic                 cmd_fifo_empty,
    input logic                 im_fifo_rd_en,
    input logic                 im_fifo_empty,
    input logic                 iwb_fifo_rd_en,
    input logic                 iwb_fifo_empty,
    input logic                 conv_valid,
    input logic                 pool_valid,
    input logic                 conv_res_valid,
    input logic                 pool_res_valid,
    input logic                 result_valid,
    input logic                 result_ready,
    input cnn_cmd_pkg::result_t result,
    input logic                 irq
);

    // FIFO reads only with a word present
    a_cmd_rd: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_fifo_rd_en |-> !cmd_fifo_empty)
        else $error("command FIFO read while empty");

    a_im_rd: assert property (@(posedge clk) disable iff (!rst_n)
        im_fifo_rd_en |-> !im_fifo_empty)
        else $error("image FIFO read while empty");

    a_iwb_rd: assert property (@(posedge clk) disable iff (!rst_n)
        iwb_fifo_rd_en |-> !iwb_fifo_empty)
        else $error("weight FIFO read while empty");

    // Held result keeps valid and data
    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("result changed or dropped while stalled");

    // irq only once both engines are drained
    a_irq_idle: assert property (@(posedge clk) disable iff (!rst_n)
        irq |-> !conv_valid && !pool_valid && !conv_res_valid && !pool_res_valid)
        else $error("irq raised with an engine busy");

endmodule

/* src/cnn_core_top.sv */
module cnn_core_top #(
    parameter int frac_bits = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 op_en,
    output logic                 cmd_fifo_rd_en,
    input  logic [31:0]          cmd,
    input  logic                 cmd_fifo_empty,
    output logic                 im_fifo_rd_en,
    input  logic [31:0]          data,
    input  logic                 im_fifo_empty,
    output logic                 iwb_fifo_rd_en,
    input  logic [31:0]          weightbias,
    input  logic                 iwb_fifo_empty,
    output logic                 result_valid,
    output cnn_cmd_pkg::result_t result,
    input  logic                 result_ready,
    output logic                 irq
);
    import cnn_data_pkg::*;

    window_t win;
    weight_set_t wb;
    logic conv_valid;
    logic conv_ready;
    logic pool_valid;
    logic pool_ready;
    logic conv_res_valid;
    logic conv_res_ready;
    logic pool_res_valid;
    logic pool_res_ready;
    logic signed [PIX_W-1:0] conv_res;
    logic signed [PIX_W-1:0] pool_res;

    csb u_csb (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_en          (op_en),
        .cmd_fifo_rd_en (cmd_fifo_rd_en),
        .cmd            (cmd),
        .cmd_fifo_empty (cmd_fifo_empty),
        .im_fifo_rd_en  (im_fifo_rd_en),
        .data           (data),
        .im_fifo_empty  (im_fifo_empty),
        .iwb_fifo_rd_en (iwb_fifo_rd_en),
        .weightbias     (weightbias),
        .iwb_fifo_empty (iwb_fifo_empty),
        .win            (win),
        .wb             (wb),
        .conv_valid     (conv_valid),
        .conv_ready     (conv_ready),
        .pool_valid     (pool_valid),
        .pool_ready     (pool_ready),
        .conv_res_valid (conv_res_valid),
        .conv_res       (conv_res),
        .conv_res_ready (conv_res_ready),
        .pool_res_valid (pool_res_valid),
        .pool_res       (pool_res),
        .pool_res_ready (pool_res_ready),
        .result_valid   (result_valid),
        .result         (result),
        .result_ready   (result_ready),
        .irq            (irq)
    );

    conv3x3_mac #(
        .frac_bits (frac_bits)
    ) u_conv (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (conv_valid),
        .win       (win),
        .wb        (wb),
        .in_ready  (conv_ready),
        .out_valid (conv_res_valid),
        .out_value (conv_res),
        .out_ready (conv_res_ready)
    );

    pool3x3_max u_pool (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (pool_valid),
        .win       (win),
        .in_ready  (pool_ready),
        .out_valid (pool_res_valid),
        .out_value (pool_res),
        .out_ready (pool_res_ready)
    );

endmodule

/* src/pool3x3_max.sv */
module pool3x3_max (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  cnn_data_pkg::window_t                 win,
    output logic                                  in_ready,
    output logic                                  out_valid,
    output logic signed [cnn_data_pkg::PIX_W-1:0] out_value,
    input  logic                                  out_ready
);
    import cnn_data_pkg::*;

    pix_t max_c;

    // Signed compare across the window
    always_comb begin
        max_c = win[0];
        for (int i = 1; i < WIN_PIX; i++) begin
            if (win[i] > max_c) max_c = win[i];
        end
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) out_value <= max_c;
    end

endmodule

/* src/conv3x3_mac.sv */
module conv3x3_mac #(
    parameter int frac_bits = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  cnn_data_pkg::window_t                 win,
    input  cnn_data_pkg::weight_set_t             wb,
    output logic                                  in_ready,
    output logic                                  out_valid,
    output logic signed [cnn_data_pkg::PIX_W-1:0] out_value,
    input  logic                                  out_ready
);
    import cnn_data_pkg::*;

    localparam int ACC_W = 2 * PIX_W;

    logic signed [ACC_W-1:0] prod_q [WIN_PIX];
    logic signed [PIX_W-1:0] bias_q;
    logic signed [ACC_W-1:0] sum_next;
    logic signed [ACC_W-1:0] sum_q;
    logic signed [ACC_W-1:0] shifted;
    logic s1_valid;
    logic s2_valid;
    logic s1_en;
    logic s2_en;

    // A stage moves when its successor is empty or draining
    assign s2_en    = !s2_valid || out_ready;
    assign s1_en    = !s1_valid || s2_en;
    assign in_ready = s1_en;
    assign out_valid = s2_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_en) s1_valid <= in_valid;
            if (s2_en) s2_valid <= s1_valid;
        end
    end

    // Stage 1, the nine products
    always_ff @(posedge clk) begin
        if (s1_en && in_valid) begin
            for (int i = 0; i < WIN_PIX; i++) begin
                prod_q[i] <= $signed(win[i]) * $signed(wb.w[i]);
            end
            bias_q <= wb.bias;
        end
    end

    always_comb begin
        sum_next = bias_q;
        for (int i = 0; i < WIN_PIX; i++) begin
            sum_next = sum_next + prod_q[i];
        end
    end

    // Stage 2, adder tree plus bias
    always_ff @(posedge clk) begin
        if (s2_en && s1_valid) sum_q <= sum_next;
    end

    // Fixed-point scaling, ReLU and saturation
    assign shifted = sum_q >>> frac_bits;

    always_comb begin
        if (shifted < 0) begin
            out_value = '0;
        end else if (shifted > 32'sd32767) begin
            out_value = 16'sd32767;
        end else begin
            out_value = shifted[PIX_W-1:0];
        end
    end

endmodule

/* src/csb.sv */
module csb (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                op_en,
    output logic                                cmd_fifo_rd_en,
    input  logic [31:0]                         cmd,
    input  logic                                cmd_fifo_empty,
    output logic                                im_fifo_rd_en,
    input  logic [31:0]                         data,
    input  logic                                im_fifo_empty,
    output logic                                iwb_fifo_rd_en,
    input  logic [31:0]                         weightbias,
    input  logic                                iwb_fifo_empty,
    output cnn_data_pkg::window_t               win,
    output cnn_data_pkg::weight_set_t           wb,
    output logic                                conv_valid,
    input  logic                                conv_ready,
    output logic                                pool_valid,
    input  logic                                pool_ready,
    input  logic                                conv_res_valid,
    input  logic signed [cnn_data_pkg::PIX_W-1:0] conv_res,
    output logic                                conv_res_ready,
    input  logic                                pool_res_valid,
    input  logic signed [cnn_data_pkg::PIX_W-1:0] pool_res,
    output logic                                pool_res_ready,
    output logic                                result_valid,
    output cnn_cmd_pkg::result_t                result,
    input  logic                                result_ready,
    output logic                                irq
);
    import cnn_cmd_pkg::*;
    import cnn_data_pkg::*;

    localparam int CMD_CNT_W = $clog2(CMD_WORDS);
    localparam int OPW_CNT_W = $clog2(OPERAND_WORDS);
    localparam logic [CMD_CNT_W-1:0] CMD_LAST = CMD_CNT_W'(CMD_WORDS - 1);
    localparam logic [OPW_CNT_W-1:0] OPW_LAST = OPW_CNT_W'(OPERAND_WORDS - 1);

    csb_state_e state;
    csb_state_e next_state;
    op_e op_q;

    logic [CMD_CNT_W-1:0] cmd_cnt;
    logic [OPW_CNT_W-1:0] opw_cnt;
    logic [15:0] win_total;
    logic [15:0] issued_cnt;
    logic [15:0] res_cnt;
    logic [31:0] w_addr_q;
    logic win_full;

    logic cmd_fire;
    logic cmd_last;
    logic wb_fire;
    logic im_fire;
    logic opw_last;
    logic disp_fire;
    logic res_fire;
    logic op_supported;
    logic all_issued;
    logic cmd_done;

    assign cmd_last = (cmd_cnt == CMD_LAST);
    assign opw_last = (opw_cnt == OPW_LAST);
    assign op_supported = (op_q == OP_CONV3X3) || (op_q == OP_POOL3X3);
    assign all_issued = (issued_cnt == win_total) && !win_full;
    // Unsupported op codes finish right after their command words
    assign cmd_done = (res_cnt == win_total) || !op_supported;

    // FIFO reads, first-word-fall-through so data is valid with !empty
    assign cmd_fifo_rd_en = (state == CMD_COLLECT) && !cmd_fifo_empty;
    assign iwb_fifo_rd_en = (state == LOAD_WEIGHTS) && !iwb_fifo_empty;
    // Stop filling once the window is complete and waiting for dispatch
    assign im_fifo_rd_en = (state == ISSUE) && !win_full && (issued_cnt != win_total)
                           && !im_fifo_empty;

    assign cmd_fire = cmd_fifo_rd_en;
    assign wb_fire  = iwb_fifo_rd_en;
    assign im_fire  = im_fifo_rd_en;

    assign conv_valid = win_full && (op_q == OP_CONV3X3);
    assign pool_valid = win_full && (op_q == OP_POOL3X3);
    assign disp_fire  = (conv_valid && conv_ready) || (pool_valid && pool_ready);

    assign irq = (state == FINISH);

    // Result path follows the engine of the current command
    always_comb begin
        result_valid   = 1'b0;
        result.value   = '0;
        result.w_addr  = w_addr_q;
        conv_res_ready = 1'b0;
        pool_res_ready = 1'b0;
        case (op_q)
            OP_CONV3X3: begin
                result_valid   = conv_res_valid;
                result.value   = conv_res;
                conv_res_ready = result_ready;
            end
            OP_POOL3X3: begin
                result_valid   = pool_res_valid;
                result.value   = pool_res;
                pool_res_ready = result_ready;
            end
            default: ;
        endcase
    end

    assign res_fire = result_valid && result_ready;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (op_en) next_state = CMD_COLLECT;
            end
            CMD_COLLECT: begin
                if (cmd_fire && cmd_last) begin
                    case (op_q)
                        OP_CONV3X3: next_state = LOAD_WEIGHTS;
                        OP_POOL3X3: next_state = ISSUE;
                        default:    next_state = DRAIN;
                    endcase
                end
            end
            LOAD_WEIGHTS: begin
                if (wb_fire && opw_last) next_state = ISSUE;
            end
            ISSUE: begin
                if (all_issued) next_state = DRAIN;
            end
            DRAIN: begin
                if (cmd_done) next_state = cmd_fifo_empty ? FINISH : CMD_COLLECT;
            end
            FINISH: begin
                if (!op_en) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            op_q       <= OP_IDLE;
            cmd_cnt    <= '0;
            opw_cnt    <= '0;
            win_total  <= '0;
            issued_cnt <= '0;
            res_cnt    <= '0;
            win_full   <= 1'b0;
        end else begin
            state <= next_state;
            if (cmd_fire) begin
                cmd_cnt <= cmd_last ? '0 : cmd_cnt + 1'b1;
                case (cmd_cnt)
                    CMD_CNT_W'(0): op_q <= op_e'(cmd[OP_MSB:0]);
                    CMD_CNT_W'(1): win_total <= cmd[CNT_MSB:0];
                    default: ;
                endcase
            end
            // Fresh counts for each new command
            if (cmd_fire && cmd_last) begin
                opw_cnt    <= '0;
                issued_cnt <= '0;
                res_cnt    <= '0;
            end else begin
                if (wb_fire || im_fire) opw_cnt <= opw_last ? '0 : opw_cnt + 1'b1;
                if (disp_fire) issued_cnt <= issued_cnt + 1'b1;
                if (res_fire) res_cnt <= res_cnt + 1'b1;
            end
            if (im_fire && opw_last) begin
                win_full <= 1'b1;
            end else if (disp_fire) begin
                win_full <= 1'b0;
            end
        end
    end

    // Operand unpacking and write address, two bytes per result
    always_ff @(posedge clk) begin
        if (cmd_fire && cmd_last) begin
            w_addr_q <= cmd;
        end else if (res_fire) begin
            w_addr_q <= w_addr_q + 32'd2;
        end
        if (wb_fire) begin
            wb.w[2*opw_cnt] <= weightbias[15:0];
            if (opw_last) begin
                wb.bias <= weightbias[31:16];
            end else begin
                wb.w[2*opw_cnt+1] <= weightbias[31:16];
            end
        end
        if (im_fire) begin
            win[2*opw_cnt] <= data[15:0];
            // High half of the last word is padding
            if (!opw_last) win[2*opw_cnt+1] <= data[31:16];
        end
    end

endmodule

/* src/cnn_data_pkg.sv */
package cnn_data_pkg;

    // Pixel and weight width
    localparam int PIX_W = 16;

    // Pixels per 3x3 window
    localparam int WIN_PIX = 9;

    // FIFO words per window or weight set, two halves per word, low half first
    localparam int OPERAND_WORDS = 5;

    typedef logic signed [PIX_W-1:0] pix_t;

    // Element 0 is the low half of the first word
    typedef pix_t [WIN_PIX-1:0] window_t;

    // Nine weights then the bias, bias comes from the tenth half
    typedef struct packed {
        pix_t [WIN_PIX-1:0] w;
        pix_t               bias;
    } weight_set_t;

endpackage

/* src/cnn_cmd_pkg.sv */
package cnn_cmd_pkg;

    // Words per command as they come out of the command FIFO
    //   word 0: op code in bits 2:0
    //   word 1: window count in bits 15:0
    //   word 2: read start address, not used by the sequencer
    //   word 3: write base address for the first result
    localparam int CMD_WORDS = 4;

    // Field positions inside the command words
    localparam int OP_MSB  = 2;
    localparam int CNT_MSB = 15;

    // Supported op codes, anything else is skipped
    typedef enum logic [2:0] {
        OP_IDLE    = 3'd0,
        OP_CONV3X3 = 3'd1,
        OP_POOL3X3 = 3'd3
    } op_e;

    // Sequencer FSM
    typedef enum logic [2:0] {
        IDLE,
        CMD_COLLECT,
        LOAD_WEIGHTS,
        ISSUE,
        DRAIN,
        FINISH
    } csb_state_e;

    // One tagged result on its way out
    typedef struct packed {
        logic [31:0]        w_addr;
        logic signed [15:0] value;
    } result_t;

endpackage
